/* all.f */
+incdir+verilog
+incdir+verification
verilog/alu_pkg.sv
verilog/alu_dispatch.sv
verilog/alu_dpath.sv
verilog/alu_wbck_stage.sv
verilog/alu_exec_top.sv
verification/alu_exec_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the execution stage testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  --top-module alu_exec_tb \
  -f all.f

# The log decides the result, so a fatal exit must not stop the script here
./obj_dir/Valu_exec_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation completed successfully" sim.log; then
  echo "Result: PASS"
else
  echo "Result: FAIL"
  exit 1
fi

/* verification/alu_exec_tb_vectors.svh */
`ifndef ALU_EXEC_TB_VECTORS_SVH
`define ALU_EXEC_TB_VECTORS_SVH

  // Each row gives opcode, rs1, op2 (imm when use_imm is set, else rs2),
  // ctl {use_imm, rdwen, bjp_prdt}, fetch exceptions {ilegl, buserr, misalgn},
  // expected {wbck valid, bjp, bjp_rslv, err} and expected write-back data

  task automatic build_table();
    //////////////////////////////////////////////////////////////////////
    // Regular ALU ops, register and immediate operands
    add_vec(alu_pkg::ADD,  32'h00000005, 32'h00000007, 3'b010, 3'b000, 4'b1000, 32'h0000000c);
    add_vec(alu_pkg::ADD,  32'hffffffff, 32'h00000001, 3'b110, 3'b000, 4'b1000, 32'h00000000);
    add_vec(alu_pkg::SUB,  32'h00000003, 32'h00000005, 3'b010, 3'b000, 4'b1000, 32'hfffffffe);
    add_vec(alu_pkg::XOR,  32'hf0f0f0f0, 32'h0ff00ff0, 3'b010, 3'b000, 4'b1000, 32'hff00ff00);
    add_vec(alu_pkg::SLL,  32'h80000001, 32'h00000024, 3'b010, 3'b000, 4'b1000, 32'h00000010);
    add_vec(alu_pkg::SLL,  32'h00000001, 32'h0000001f, 3'b110, 3'b000, 4'b1000, 32'h80000000);
    add_vec(alu_pkg::SRL,  32'h80000000, 32'h00000004, 3'b010, 3'b000, 4'b1000, 32'h08000000);
    add_vec(alu_pkg::SRA,  32'h80000000, 32'h00000004, 3'b010, 3'b000, 4'b1000, 32'hf8000000);
    add_vec(alu_pkg::SRA,  32'h7ffffff0, 32'h00000004, 3'b110, 3'b000, 4'b1000, 32'h07ffffff);
    add_vec(alu_pkg::OR,   32'h0000ff00, 32'h0f0f0000, 3'b010, 3'b000, 4'b1000, 32'h0f0fff00);
    add_vec(alu_pkg::AND,  32'h12345678, 32'h00000fff, 3'b110, 3'b000, 4'b1000, 32'h00000678);
    add_vec(alu_pkg::SLT,  32'hffffffff, 32'h00000001, 3'b010, 3'b000, 4'b1000, 32'h00000001);
    add_vec(alu_pkg::SLTU, 32'hffffffff, 32'h00000001, 3'b010, 3'b000, 4'b1000, 32'h00000000);
    add_vec(alu_pkg::SLT,  32'h00000005, 32'hfffffff0, 3'b110, 3'b000, 4'b1000, 32'h00000000);
    add_vec(alu_pkg::SLTU, 32'h00000001, 32'hffffffff, 3'b010, 3'b000, 4'b1000, 32'h00000001);
    add_vec(alu_pkg::LUI,  32'hdeadbeef, 32'h12345000, 3'b110, 3'b000, 4'b1000, 32'h12345000);
    add_vec(alu_pkg::ADD,  32'h00000001, 32'h00000002, 3'b000, 3'b000, 4'b0000, 32'h00000000);

    //////////////////////////////////////////////////////////////////////
    // Branches, taken and not taken
    add_vec(alu_pkg::BEQ,  32'h00000005, 32'h00000005, 3'b001, 3'b000, 4'b0110, 32'h00000000);
    add_vec(alu_pkg::BEQ,  32'h00000005, 32'h00000006, 3'b000, 3'b000, 4'b0100, 32'h00000000);
    add_vec(alu_pkg::BNE,  32'h00000005, 32'h00000006, 3'b001, 3'b000, 4'b0110, 32'h00000000);
    add_vec(alu_pkg::BNE,  32'h00000007, 32'h00000007, 3'b000, 3'b000, 4'b0100, 32'h00000000);
    add_vec(alu_pkg::BLT,  32'hffffffff, 32'h00000001, 3'b001, 3'b000, 4'b0110, 32'h00000000);
    add_vec(alu_pkg::BLTU, 32'hffffffff, 32'h00000001, 3'b000, 3'b000, 4'b0100, 32'h00000000);
    add_vec(alu_pkg::BGE,  32'hffffffff, 32'h00000001, 3'b001, 3'b000, 4'b0100, 32'h00000000);
    add_vec(alu_pkg::BGEU, 32'hffffffff, 32'h00000001, 3'b000, 3'b000, 4'b0110, 32'h00000000);
    add_vec(alu_pkg::BLT,  32'h00000002, 32'h00000002, 3'b000, 3'b000, 4'b0100, 32'h00000000);
    add_vec(alu_pkg::BGE,  32'h00000002, 32'h00000002, 3'b000, 3'b000, 4'b0110, 32'h00000000);
    add_vec(alu_pkg::BLTU, 32'h00000001, 32'h00000002, 3'b001, 3'b000, 4'b0110, 32'h00000000);
    add_vec(alu_pkg::BGEU, 32'h00000001, 32'h00000002, 3'b001, 3'b000, 4'b0100, 32'h00000000);

    // Link values follow from this pc
    set_pc(32'h00004000);
    add_vec(alu_pkg::JAL,  32'h00000000, 32'h00000000, 3'b011, 3'b000, 4'b1110, 32'h00004004);
    add_vec(alu_pkg::JAL,  32'h00000000, 32'h00000000, 3'b010, 3'b000, 4'b1110, 32'h00004008);

    //////////////////////////////////////////////////////////////////////
    // Fetch exceptions, no write-back even with rdwen
    add_vec(alu_pkg::ADD,  32'h00000005, 32'h00000007, 3'b010, 3'b100, 4'b0001, 32'h00000000);
    add_vec(alu_pkg::BEQ,  32'h00000005, 32'h00000005, 3'b011, 3'b010, 4'b0001, 32'h00000000);
    add_vec(alu_pkg::SUB,  32'h00000003, 32'h00000001, 3'b000, 3'b001, 4'b0001, 32'h00000000);
    add_vec(alu_pkg::JAL,  32'h00000000, 32'h00000000, 3'b011, 3'b111, 4'b0001, 32'h00000000);
    add_vec(alu_pkg::XOR,  32'h0000ffff, 32'hffff0000, 3'b010, 3'b000, 4'b1000, 32'hffffffff);
  endtask

`endif

/* verification/alu_exec_tb.sv */
`timescale 1ns/1ps

`include "alu_consts.svh"

module alu_exec_tb;

  typedef struct packed {
    alu_pkg::alu_issue_t  iss;
    logic                 wb;
    logic                 bjp;
    logic                 rslv;
    logic                 err;
    logic [`ALU_XLEN-1:0] wdat;
  } vec_t;

  localparam int DRAIN_LIMIT = 8;  // Cycles allowed after the last issue
  localparam int NUM_RANDOM  = 48;

  logic                 clk;
  logic                 i_rst_n;
  logic                 i_valid;
  alu_pkg::alu_issue_t  i_issue;
  alu_pkg::alu_wbck_t   o_wbck;
  alu_pkg::alu_cmt_t    o_cmt;

  vec_t                 vec_q[$];
  int                   pend_idx_q[$]; // Table index of each instruction in flight
  int                   pend_cyc_q[$]; // Cycle it was driven
  int                   cyc;
  int                   seed;
  logic [`ALU_PC_W-1:0] cur_pc;

  alu_exec_top u_alu_exec_top (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_valid (i_valid),
    .i_issue (i_issue),
    .o_wbck  (o_wbck),
    .o_cmt   (o_cmt)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Error reporting and table building

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else
      report_error($sformatf("[FAIL] %0t ns: %s expected %h, actual %h", $time, name, exp, act));
  endtask

  task automatic set_pc(input logic [`ALU_PC_W-1:0] pc);
    cur_pc = pc;
  endtask

  task automatic add_vec(input alu_pkg::alu_opc_e opc, input logic [31:0] rs1,
                         input logic [31:0] op2, input logic [2:0] ctl,
                         input logic [2:0] excp, input logic [3:0] exp_flags,
                         input logic [31:0] exp_wdat);
    vec_t v;
    v = '0;
    v.iss.opc      = opc;
    v.iss.rs1      = rs1;
    v.iss.use_imm  = ctl[2];
    v.iss.rdwen    = ctl[1];
    v.iss.bjp_prdt = ctl[0];
    v.iss.imm      = ctl[2] ? op2 : ~op2; // Unused operand gets a decoy
    v.iss.rs2      = ctl[2] ? ~op2 : op2;
    v.iss.pc       = cur_pc;
    v.iss.rdidx    = `ALU_RFIDX_W'((vec_q.size() % 31) + 1);
    {v.iss.ifu_ilegl, v.iss.ifu_buserr, v.iss.ifu_misalgn} = excp;
    {v.wb, v.bjp, v.rslv, v.err} = exp_flags;
    v.wdat = exp_wdat;
    cur_pc = cur_pc + `ALU_PC_W'(`ALU_INSTR_BYTES);
    vec_q.push_back(v);
  endtask

  `include "alu_exec_tb_vectors.svh"

  // Reference model for the random section
  function automatic logic [31:0] ref_alu(input alu_pkg::alu_opc_e opc,
                                         input logic [31:0] a, input logic [31:0] b);
    case (opc)
      alu_pkg::ADD: return a + b;
      alu_pkg::SUB: return a - b;
      alu_pkg::XOR: return a ^ b;
      alu_pkg::SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      alu_pkg::SRA: return $signed(a) >>> b[`ALU_SHAMT_W-1:0];
      default:      return 32'd0;
    endcase
  endfunction

  task automatic build_random(input int count);
    alu_pkg::alu_opc_e opc;
    logic [31:0]       a;
    logic [31:0]       b;
    logic [31:0]       r;
    int                k;
    for (int i = 0; i < count; i++) begin
      r = $random(seed);
      k = int'(r % 5);
      case (k)
        0:       opc = alu_pkg::ADD;
        1:       opc = alu_pkg::SUB;
        2:       opc = alu_pkg::XOR;
        3:       opc = alu_pkg::SLT;
        default: opc = alu_pkg::SRA;
      endcase
      a = $random(seed);
      b = $random(seed);
      add_vec(opc, a, b, {r[8], 2'b10}, 3'b000, 4'b1000, ref_alu(opc, a, b));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stepping and output checks, all on the falling edge

  task automatic step();
    @(negedge clk);
    cyc++;
  endtask

  task automatic check_outputs();
    vec_t v;
    if (o_wbck.valid === 1'b1) begin
      assert (o_cmt.valid === 1'b1) else report_error("Write-back valid without a commit");
    end
    if (o_cmt.valid === 1'b1) begin
      assert (pend_idx_q.size() != 0) else report_error("Commit with no instruction in flight");
      assert (cyc == pend_cyc_q[0] + 2) else report_error("Commit arrived at the wrong cycle");
      v = vec_q[pend_idx_q[0]];
      check_val("o_cmt.pc", v.iss.pc, o_cmt.pc);
      check_val("o_cmt.bjp", 32'(v.bjp), 32'(o_cmt.bjp));
      check_val("o_cmt.bjp_prdt", 32'(v.bjp & v.iss.bjp_prdt), 32'(o_cmt.bjp_prdt));
      check_val("o_cmt.bjp_rslv", 32'(v.rslv), 32'(o_cmt.bjp_rslv));
      check_val("o_cmt.err", 32'(v.err), 32'(o_cmt.err));
      check_val("o_cmt.ifu_flags",
                32'({v.iss.ifu_ilegl, v.iss.ifu_buserr, v.iss.ifu_misalgn}),
                32'({o_cmt.ifu_ilegl, o_cmt.ifu_buserr, o_cmt.ifu_misalgn}));
      check_val("o_wbck.valid", 32'(v.wb), 32'(o_wbck.valid));
      if (v.wb) begin
        check_val("o_wbck.rdidx", 32'(v.iss.rdidx), 32'(o_wbck.rdidx));
        check_val("o_wbck.wdat", v.wdat, o_wbck.wdat);
      end
      void'(pend_idx_q.pop_front());
      void'(pend_cyc_q.pop_front());
    end else begin
      check_val("o_cmt.valid", 32'd0, 32'(o_cmt.valid));
      check_val("o_wbck.valid", 32'd0, 32'(o_wbck.valid));
      if (pend_cyc_q.size() != 0) begin
        assert (cyc < pend_cyc_q[0] + 2) else report_error("No commit two cycles after issue");
      end
    end
  endtask

  task automatic idle_cycles(input int count);
    i_valid = 1'b0;
    for (int i = 0; i < count; i++) begin
      step();
      check_outputs();
    end
  endtask

  // Back-to-back issue, one entry per cycle, then drain
  task automatic run_vectors();
    int idx;
    int drain;
    idx   = 0;
    drain = 0;
    while (idx < vec_q.size() || pend_idx_q.size() != 0) begin
      step();
      check_outputs();
      if (idx < vec_q.size()) begin
        i_valid = 1'b1;
        i_issue = vec_q[idx].iss;
        pend_idx_q.push_back(idx);
        pend_cyc_q.push_back(cyc);
        idx++;
      end else begin
        i_valid = 1'b0;
        i_issue = '0;
        drain++;
        assert (drain <= DRAIN_LIMIT) else report_error("Timed out waiting for commits");
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence

  initial begin
    seed    = 32'h1020_347b;
    cyc     = 0;
    cur_pc  = 32'h0000_1000;
    i_rst_n = 1'b0;
    i_valid = 1'b0;
    i_issue = '0;
    for (int n = 0; n < 10; n++) begin
      step();
      check_outputs(); // Valids must stay low in reset
    end
    i_rst_n = 1'b1;
    idle_cycles(6);
    build_table();
    run_vectors();
    idle_cycles(4);
    vec_q.delete();
    build_random(NUM_RANDOM);
    run_vectors();
    idle_cycles(4);
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

/* verilog/alu_consts.svh */
`ifndef ALU_CONSTS_SVH
`define ALU_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// Execution stage widths, fixed by RV32I

// Data word
`define ALU_XLEN 32

// Program counter
`define ALU_PC_W 32

// Register file index, x0..x31
`define ALU_RFIDX_W 5

// Shift amount taken from the low bits of op2
`define ALU_SHAMT_W 5

`define ALU_INSTR_BYTES 4 // Link increment, no compressed instructions

`endif

/* verilog/alu_dispatch.sv */
`timescale 1ns/1ps

`include "alu_consts.svh"

module alu_dispatch (
  input  logic                clk,
  input  logic                i_rst_n,
  input  logic                i_valid,
  input  alu_pkg::alu_issue_t i_issue,
  output logic                o_req_valid,
  output alu_pkg::alu_req_t   o_req
);

  logic              excp_op;
  logic              bjp_opc;
  alu_pkg::alu_req_t req_nxt;

  //////////////////////////////////////////////////////////////////////
  // Classify

  // Any fetch exception overrides the opcode
  assign excp_op = i_issue.ifu_ilegl | i_issue.ifu_buserr | i_issue.ifu_misalgn;

  always_comb begin
    case (i_issue.opc)
      alu_pkg::BEQ,
      alu_pkg::BNE,
      alu_pkg::BLT,
      alu_pkg::BGE,
      alu_pkg::BLTU,
      alu_pkg::BGEU,
      alu_pkg::JAL: bjp_opc = 1'b1;
      default:      bjp_opc = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Operand select

  always_comb begin
    req_nxt = '0; // Unused operands stay zero

    if (excp_op) begin
      req_nxt.grp = alu_pkg::GRP_EXCP;
    end else if (bjp_opc) begin
      req_nxt.grp = alu_pkg::GRP_BJP;
    end else begin
      req_nxt.grp = alu_pkg::GRP_ALU;
    end

    req_nxt.opc         = i_issue.opc;
    req_nxt.pc          = i_issue.pc;
    req_nxt.rdidx       = i_issue.rdidx;
    req_nxt.rdwen       = i_issue.rdwen;
    req_nxt.bjp_prdt    = i_issue.bjp_prdt;
    req_nxt.ifu_ilegl   = i_issue.ifu_ilegl;
    req_nxt.ifu_buserr  = i_issue.ifu_buserr;
    req_nxt.ifu_misalgn = i_issue.ifu_misalgn;

    case (req_nxt.grp)
      alu_pkg::GRP_ALU: begin
        req_nxt.op1 = i_issue.rs1;
        req_nxt.op2 = i_issue.use_imm ? i_issue.imm : i_issue.rs2;
      end
      alu_pkg::GRP_BJP: begin
        // Adder forms the link value pc + 4
        req_nxt.op1   = i_issue.pc;
        req_nxt.op2   = `ALU_XLEN'(`ALU_INSTR_BYTES);
        req_nxt.cmp_a = i_issue.rs1;
        req_nxt.cmp_b = i_issue.rs2;
      end
      default: ;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Request register

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_req_valid <= 1'b0;
    end else begin
      o_req_valid <= i_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (i_valid) begin
      o_req <= req_nxt;
    end
  end

  // Issued opcode is one of the defined encodings
  a_opc_legal: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_valid |-> (i_issue.opc <= alu_pkg::JAL));

endmodule

/* verilog/alu_dpath.sv */
`timescale 1ns/1ps

`include "alu_consts.svh"

module alu_dpath (
  input  alu_pkg::alu_req_t i_req,
  output alu_pkg::alu_res_t o_res
);

  logic                    is_sub;
  logic                    sign_ext;
  logic [`ALU_XLEN:0]      add_a;
  logic [`ALU_XLEN:0]      add_b;
  logic [`ALU_XLEN:0]      add_res;
  logic [`ALU_SHAMT_W-1:0] shamt;
  logic [`ALU_XLEN-1:0]    sh_in;
  logic [`ALU_XLEN:0]      sh_ext;
  logic [`ALU_XLEN-1:0]    sh_res;
  logic                    cmp_eq;
  logic                    cmp_lt;
  logic                    cmp_ltu;

  function automatic logic [`ALU_XLEN-1:0] bit_rev(input logic [`ALU_XLEN-1:0] din);
    logic [`ALU_XLEN-1:0] dout;
    for (int i = 0; i < `ALU_XLEN; i++) begin
      dout[i] = din[`ALU_XLEN-1-i];
    end
    return dout;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Shared adder, 33 bits so bit 32 is the less-than flag

  assign is_sub   = (i_req.opc == alu_pkg::SUB) | (i_req.opc == alu_pkg::SLT)
                  | (i_req.opc == alu_pkg::SLTU);
  assign sign_ext = (i_req.opc == alu_pkg::SLT);

  assign add_a   = {sign_ext & i_req.op1[`ALU_XLEN-1], i_req.op1};
  assign add_b   = {sign_ext & i_req.op2[`ALU_XLEN-1], i_req.op2};
  assign add_res = add_a + (add_b ^ {(`ALU_XLEN+1){is_sub}})
                 + {{`ALU_XLEN{1'b0}}, is_sub}; // Two's complement subtract

  //////////////////////////////////////////////////////////////////////
  // Shared shifter, left shift done by reversing around a right shift

  assign shamt  = i_req.op2[`ALU_SHAMT_W-1:0];
  assign sh_in  = (i_req.opc == alu_pkg::SLL) ? bit_rev(i_req.op1) : i_req.op1;
  assign sh_ext = $signed({(i_req.opc == alu_pkg::SRA) & i_req.op1[`ALU_XLEN-1], sh_in})
                >>> shamt;
  assign sh_res = sh_ext[`ALU_XLEN-1:0];

  // Branch comparator
  assign cmp_eq  = (i_req.cmp_a == i_req.cmp_b);
  assign cmp_ltu = (i_req.cmp_a < i_req.cmp_b);
  assign cmp_lt  = ($signed(i_req.cmp_a) < $signed(i_req.cmp_b));

  //////////////////////////////////////////////////////////////////////
  // Result select

  always_comb begin
    o_res = '0;
    case (i_req.grp)
      alu_pkg::GRP_ALU: begin
        case (i_req.opc)
          alu_pkg::ADD,
          alu_pkg::SUB:  o_res.wdat = add_res[`ALU_XLEN-1:0];
          alu_pkg::XOR:  o_res.wdat = i_req.op1 ^ i_req.op2;
          alu_pkg::SLL:  o_res.wdat = bit_rev(sh_res);
          alu_pkg::SRL,
          alu_pkg::SRA:  o_res.wdat = sh_res;
          alu_pkg::OR:   o_res.wdat = i_req.op1 | i_req.op2;
          alu_pkg::AND:  o_res.wdat = i_req.op1 & i_req.op2;
          alu_pkg::SLT,
          alu_pkg::SLTU: o_res.wdat = {{(`ALU_XLEN-1){1'b0}}, add_res[`ALU_XLEN]};
          alu_pkg::LUI:  o_res.wdat = i_req.op2; // Immediate already shifted
          default:       o_res.wdat = '0;
        endcase
      end
      alu_pkg::GRP_BJP: begin
        o_res.wdat = add_res[`ALU_XLEN-1:0]; // Link value
        case (i_req.opc)
          alu_pkg::BEQ:  o_res.cmp_res = cmp_eq;
          alu_pkg::BNE:  o_res.cmp_res = ~cmp_eq;
          alu_pkg::BLT:  o_res.cmp_res = cmp_lt;
          alu_pkg::BGE:  o_res.cmp_res = ~cmp_lt;
          alu_pkg::BLTU: o_res.cmp_res = cmp_ltu;
          alu_pkg::BGEU: o_res.cmp_res = ~cmp_ltu;
          alu_pkg::JAL:  o_res.cmp_res = 1'b1;
          default:       o_res.cmp_res = 1'b0;
        endcase
      end
      default: ;
    endcase
  end

endmodule

/* verilog/alu_exec_top.sv */
`timescale 1ns/1ps

module alu_exec_top (
  input  logic                clk,
  input  logic                i_rst_n,
  input  logic                i_valid,
  input  alu_pkg::alu_issue_t i_issue,
  output alu_pkg::alu_wbck_t  o_wbck,
  output alu_pkg::alu_cmt_t   o_cmt
);

  logic              req_valid;
  alu_pkg::alu_req_t req;
  alu_pkg::alu_res_t res;

  //////////////////////////////////////////////////////////////////////
  // Dispatch, one cycle

  alu_dispatch u_alu_dispatch (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_valid     (i_valid),
    .i_issue     (i_issue),
    .o_req_valid (req_valid),
    .o_req       (req)
  );

  // Shared datapath, combinational
  alu_dpath u_alu_dpath (
    .i_req (req),
    .o_res (res)
  );

  //////////////////////////////////////////////////////////////////////
  // Write-back and commit, one cycle

  alu_wbck_stage u_alu_wbck_stage (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_req_valid (req_valid),
    .i_req       (req),
    .i_res       (res),
    .o_wbck      (o_wbck),
    .o_cmt       (o_cmt)
  );

endmodule

/* verilog/alu_pkg.sv */
`include "alu_consts.svh"

package alu_pkg;

  //////////////////////////////////////////////////////////////////////
  // Opcodes and instruction groups

  typedef enum logic [4:0] {
    ADD, SUB, XOR, SLL, SRL, SRA, OR, AND, SLT, SLTU, LUI, // Regular ALU
    BEQ, BNE, BLT, BGE, BLTU, BGEU, JAL                    // Branch and jump
  } alu_opc_e;

  typedef enum logic [1:0] {
    GRP_ALU,
    GRP_BJP,
    GRP_EXCP // Fetch exception, no compute
  } alu_grp_e;

  //////////////////////////////////////////////////////////////////////
  // Packets between the stages

  // Decoded instruction from issue
  typedef struct packed {
    alu_opc_e                 opc;
    logic [`ALU_XLEN-1:0]     rs1;
    logic [`ALU_XLEN-1:0]     rs2;
    logic [`ALU_XLEN-1:0]     imm;
    logic [`ALU_PC_W-1:0]     pc;
    logic [`ALU_RFIDX_W-1:0]  rdidx;
    logic                     rdwen;
    logic                     use_imm;     // op2 from imm instead of rs2
    logic                     bjp_prdt;    // Predicted taken
    logic                     ifu_ilegl;
    logic                     ifu_buserr;
    logic                     ifu_misalgn;
  } alu_issue_t;

  // Request held in front of the shared datapath
  typedef struct packed {
    alu_grp_e                 grp;
    alu_opc_e                 opc;
    logic [`ALU_XLEN-1:0]     op1;
    logic [`ALU_XLEN-1:0]     op2;
    logic [`ALU_XLEN-1:0]     cmp_a;       // Branch compare operands
    logic [`ALU_XLEN-1:0]     cmp_b;
    logic [`ALU_PC_W-1:0]     pc;
    logic [`ALU_RFIDX_W-1:0]  rdidx;
    logic                     rdwen;
    logic                     bjp_prdt;
    logic                     ifu_ilegl;
    logic                     ifu_buserr;
    logic                     ifu_misalgn;
  } alu_req_t;

  typedef struct packed {
    logic [`ALU_XLEN-1:0]     wdat;
    logic                     cmp_res;
  } alu_res_t;

  typedef struct packed {
    logic                     valid;
    logic [`ALU_RFIDX_W-1:0]  rdidx;
    logic [`ALU_XLEN-1:0]     wdat;
  } alu_wbck_t;

  typedef struct packed {
    logic                     valid;
    logic [`ALU_PC_W-1:0]     pc;
    logic                     bjp;
    logic                     bjp_prdt;
    logic                     bjp_rslv;    // Resolved taken
    logic                     err;
    logic                     ifu_ilegl;
    logic                     ifu_buserr;
    logic                     ifu_misalgn;
  } alu_cmt_t;

endpackage

/* verilog/alu_wbck_stage.sv */
`timescale 1ns/1ps

module alu_wbck_stage (
  input  logic               clk,
  input  logic               i_rst_n,
  input  logic               i_req_valid,
  input  alu_pkg::alu_req_t  i_req,
  input  alu_pkg::alu_res_t  i_res,
  output alu_pkg::alu_wbck_t o_wbck,
  output alu_pkg::alu_cmt_t  o_cmt
);

  logic               err;
  logic               is_bjp;
  logic               need_wbck;
  logic               out_vld_r;
  alu_pkg::alu_wbck_t wbck_nxt;
  alu_pkg::alu_wbck_t wbck_r;
  alu_pkg::alu_cmt_t  cmt_nxt;
  alu_pkg::alu_cmt_t  cmt_r;

  //////////////////////////////////////////////////////////////////////
  // Packet build

  assign err    = (i_req.grp == alu_pkg::GRP_EXCP);
  assign is_bjp = (i_req.grp == alu_pkg::GRP_BJP);

  // Only a clean instruction with rd enabled writes the register file
  assign need_wbck = i_req.rdwen & ~err;

  always_comb begin
    wbck_nxt       = '0;
    wbck_nxt.valid = need_wbck;
    wbck_nxt.rdidx = i_req.rdidx;
    wbck_nxt.wdat  = i_res.wdat;
  end

  always_comb begin
    cmt_nxt             = '0;
    cmt_nxt.valid       = i_req_valid;
    cmt_nxt.pc          = i_req.pc;
    cmt_nxt.bjp         = is_bjp;
    cmt_nxt.bjp_prdt    = is_bjp & i_req.bjp_prdt;
    cmt_nxt.bjp_rslv    = is_bjp & i_res.cmp_res;
    cmt_nxt.err         = err;
    cmt_nxt.ifu_ilegl   = i_req.ifu_ilegl;   // Echoed for the trap logic
    cmt_nxt.ifu_buserr  = i_req.ifu_buserr;
    cmt_nxt.ifu_misalgn = i_req.ifu_misalgn;
  end

  //////////////////////////////////////////////////////////////////////
  // Output registers

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      out_vld_r <= 1'b0;
    end else begin
      out_vld_r <= i_req_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (i_req_valid) begin
      wbck_r <= wbck_nxt;
      cmt_r  <= cmt_nxt;
    end
  end

  // Stored valid fields qualify the payload of the current slot
  always_comb begin
    o_wbck       = wbck_r;
    o_wbck.valid = out_vld_r & wbck_r.valid;
    o_cmt        = cmt_r;
    o_cmt.valid  = out_vld_r & cmt_r.valid;
  end

  // Write-back never goes out without its commit
  a_wbck_with_cmt: assert property (@(posedge clk) disable iff (!i_rst_n)
    o_wbck.valid |-> o_cmt.valid);

  // Errored commits keep the register file untouched
  a_err_no_wbck: assert property (@(posedge clk) disable iff (!i_rst_n)
    (o_cmt.valid && o_cmt.err) |-> !o_wbck.valid);

endmodule
